//--- design/console_cfg.svh
`ifndef CONSOLE_CFG_SVH
`define CONSOLE_CFG_SVH

// entries in the character queue
`define CONSOLE_FIFO_DEPTH 8

// clock cycles per serial bit
`define CONSOLE_DIV_W     16
`define CONSOLE_DIV_RESET 16

`endif

//--- design/charset_pkg.sv
package charset_pkg;

	typedef logic [5:0] char_code_t; // display character code
	typedef logic [6:0] ascii_t;

	// codes 56 to 63 have no entry and go out as a space
	function automatic ascii_t to_ascii(input char_code_t code);
		ascii_t a;
		case (code)
			6'd0:    a = 7'd32; // space
			6'd1:    a = 7'd65;
			6'd2:    a = 7'd66;
			6'd3:    a = 7'd67;
			6'd4:    a = 7'd68;
			6'd5:    a = 7'd69;
			6'd6:    a = 7'd70;
			6'd7:    a = 7'd71;
			6'd8:    a = 7'd72;
			6'd9:    a = 7'd73;
			6'd10:   a = 7'd10; // line feed
			6'd11:   a = 7'd74;
			6'd12:   a = 7'd75;
			6'd13:   a = 7'd76;
			6'd14:   a = 7'd77;
			6'd15:   a = 7'd78;
			6'd16:   a = 7'd79;
			6'd17:   a = 7'd80;
			6'd18:   a = 7'd81;
			6'd19:   a = 7'd82;
			6'd20:   a = 7'd13; // carriage return
			6'd21:   a = 7'd7;  // bell
			6'd22:   a = 7'd83;
			6'd23:   a = 7'd84;
			6'd24:   a = 7'd85;
			6'd25:   a = 7'd86;
			6'd26:   a = 7'd87;
			6'd27:   a = 7'd88;
			6'd28:   a = 7'd89;
			6'd29:   a = 7'd90;
			6'd30:   a = 7'd48; // digits
			6'd31:   a = 7'd49;
			6'd32:   a = 7'd50;
			6'd33:   a = 7'd51;
			6'd34:   a = 7'd52;
			6'd35:   a = 7'd53;
			6'd36:   a = 7'd54;
			6'd37:   a = 7'd55;
			6'd38:   a = 7'd56;
			6'd39:   a = 7'd57;
			6'd40:   a = 7'd46; // punctuation from here
			6'd41:   a = 7'd44;
			6'd42:   a = 7'd40;
			6'd43:   a = 7'd41;
			6'd44:   a = 7'd43;
			6'd45:   a = 7'd45;
			6'd46:   a = 7'd42;
			6'd47:   a = 7'd47;
			6'd48:   a = 7'd61;
			6'd49:   a = 7'd36;
			6'd50:   a = 7'd60;
			6'd51:   a = 7'd62;
			6'd52:   a = 7'd64;
			6'd53:   a = 7'd59;
			6'd54:   a = 7'd58;
			6'd55:   a = 7'd39;
			default: a = 7'd32;
		endcase
		return a;
	endfunction

endpackage

//--- design/link_pkg.sv
`include "console_cfg.svh"

package link_pkg;

	typedef logic [`CONSOLE_DIV_W-1:0] divisor_t; // clocks per bit

	typedef enum logic [1:0] {
		REG_CTRL   = 2'd0,
		REG_DIV    = 2'd1,
		REG_STATUS = 2'd2
	} reg_addr_t;

	typedef enum logic {
		TX_IDLE,
		TX_SHIFT
	} tx_state_t;

endpackage

//--- design/link_ctrl_if.sv
`timescale 1ns/1ps

interface link_ctrl_if ();
	import link_pkg::*;

	logic     enable;   // new frames allowed
	logic     two_stop;
	divisor_t divisor;
	logic     busy;     // frame on the line

	modport regs (
		output enable,
		output two_stop,
		output divisor,
		input  busy
	);

	modport tx (
		input  enable,
		input  two_stop,
		input  divisor,
		output busy
	);

endinterface

//--- design/char_fifo.sv
`timescale 1ns/1ps
`include "console_cfg.svh"

module char_fifo (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    push,
	input  charset_pkg::char_code_t din,
	input  logic                    pop,
	output charset_pkg::char_code_t head,
	output logic                    not_empty,
	output logic                    full,
	output logic [3:0]              count
);
	import charset_pkg::*;

	localparam int AW = $clog2(`CONSOLE_FIFO_DEPTH);

	char_code_t    mem [`CONSOLE_FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          do_push;
	logic          do_pop;

	assign do_pop = pop & not_empty;
	assign do_push = push & (~full | do_pop); // pop frees a slot this cycle
	assign head = mem[rd_ptr]; // fall through
	assign not_empty = count != 4'd0;
	assign full = count == 4'(`CONSOLE_FIFO_DEPTH);

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= 4'd0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 4'd1;
				2'b01:   count <= count - 4'd1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- design/console_regs.sv
`timescale 1ns/1ps
`include "console_cfg.svh"

module console_regs (
	input  logic                clk,
	input  logic                rst,
	input  logic                reg_wr,
	input  link_pkg::reg_addr_t reg_addr,
	input  logic [15:0]         reg_wdata,
	output logic [15:0]         reg_rdata,
	input  logic                push_drop,
	input  logic [3:0]          fifo_count,
	link_ctrl_if.regs           ctrl
);
	import link_pkg::*;

	logic overflow; // sticky until cleared by host
	logic wr_ctrl;
	logic wr_div;
	logic wr_status;

	assign wr_ctrl = reg_wr && (reg_addr == REG_CTRL);
	assign wr_div = reg_wr && (reg_addr == REG_DIV);
	assign wr_status = reg_wr && (reg_addr == REG_STATUS);

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl.enable <= 1'b0;
			ctrl.two_stop <= 1'b0;
		end else if (wr_ctrl) begin
			ctrl.enable <= reg_wdata[0];
			ctrl.two_stop <= reg_wdata[1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			ctrl.divisor <= divisor_t'(`CONSOLE_DIV_RESET);
		else if (wr_div)
			ctrl.divisor <= reg_wdata[`CONSOLE_DIV_W-1:0];
	end

	// a drop in the same cycle as the clear wins
	always_ff @(posedge clk) begin
		if (rst)
			overflow <= 1'b0;
		else if (push_drop)
			overflow <= 1'b1;
		else if (wr_status && reg_wdata[4])
			overflow <= 1'b0;
	end

	always_comb begin
		reg_rdata = 16'h0000;
		case (reg_addr)
			REG_CTRL:   reg_rdata = {14'd0, ctrl.two_stop, ctrl.enable};
			REG_DIV:    reg_rdata = 16'(ctrl.divisor);
			REG_STATUS: reg_rdata = {10'd0, ctrl.busy, overflow, fifo_count};
			default:    reg_rdata = 16'h0000; // unmapped
		endcase
	end

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
	input  logic                    clk,
	input  logic                    rst,
	link_ctrl_if.tx                 ctrl,
	input  charset_pkg::char_code_t head,
	input  logic                    not_empty,
	output logic                    pop,
	output logic                    tx
);
	import charset_pkg::*;
	import link_pkg::*;

	tx_state_t   state;
	divisor_t    div_eff;
	divisor_t    div_q;    // held for the whole frame
	divisor_t    per_cnt;  // cycles into current bit
	logic [3:0]  bit_cnt;
	logic [3:0]  last_bit;
	logic [10:0] shifter;
	logic        ready;
	logic        tick;

	assign div_eff = (ctrl.divisor < divisor_t'(2)) ? divisor_t'(2) : ctrl.divisor;
	assign ready = state == TX_IDLE;
	assign pop = ctrl.enable & not_empty & ready; // load together with ready
	assign tick = (state == TX_SHIFT) && (per_cnt == div_q - divisor_t'(1));
	assign ctrl.busy = ~ready;
	assign tx = ready | shifter[0]; // line rests high

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= TX_IDLE;
			per_cnt <= '0;
			bit_cnt <= 4'd0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (pop) begin
						state <= TX_SHIFT;
						per_cnt <= '0;
						bit_cnt <= 4'd0;
					end
				end
				TX_SHIFT: begin
					if (tick) begin
						per_cnt <= '0;
						if (bit_cnt == last_bit)
							state <= TX_IDLE; // stop bit done
						else
							bit_cnt <= bit_cnt + 4'd1;
					end else begin
						per_cnt <= per_cnt + divisor_t'(1);
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// start, 7 data bits, zero msb, then stop bits
	always_ff @(posedge clk) begin
		if (pop) begin
			shifter <= {2'b11, 1'b0, to_ascii(head), 1'b0};
			div_q <= div_eff;
			last_bit <= ctrl.two_stop ? 4'd10 : 4'd9; // bit 10 only with two stops
		end else if (tick) begin
			shifter <= {1'b1, shifter[10:1]};
		end
	end

endmodule

//--- design/console_top.sv
`timescale 1ns/1ps

module console_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        char_valid,
	input  logic [5:0]  char_code,
	input  logic        reg_wr,
	input  logic [1:0]  reg_addr,
	input  logic [15:0] reg_wdata,
	output logic [15:0] reg_rdata,
	output logic        tx,
	output logic        tx_idle
);
	import charset_pkg::*;
	import link_pkg::*;

	char_code_t head;
	logic       not_empty;
	logic       full;
	logic       pop;
	logic       push_drop;
	logic [3:0] count;

	link_ctrl_if ctrl_if ();

	// a push that meets a pop on a full queue still fits
	assign push_drop = char_valid & full & ~pop;
	assign tx_idle = ~ctrl_if.busy & ~not_empty;

	char_fifo u_fifo (
		.clk       (clk),
		.rst       (rst),
		.push      (char_valid),
		.din       (char_code),
		.pop       (pop),
		.head      (head),
		.not_empty (not_empty),
		.full      (full),
		.count     (count)
	);

	console_regs u_regs (
		.clk        (clk),
		.rst        (rst),
		.reg_wr     (reg_wr),
		.reg_addr   (reg_addr_t'(reg_addr)),
		.reg_wdata  (reg_wdata),
		.reg_rdata  (reg_rdata),
		.push_drop  (push_drop),
		.fifo_count (count),
		.ctrl       (ctrl_if.regs)
	);

	uart_tx u_tx (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrl_if.tx),
		.head      (head),
		.not_empty (not_empty),
		.pop       (pop),
		.tx        (tx)
	);

endmodule

//--- test/console_tb.sv
`timescale 1ns/1ps

module console_tb;

	localparam int clk_period = 40;
	localparam int max_div = 20;
	localparam int total_frames = 40 + 7 + 8 + 24 + 5;
	localparam int cycle_limit = total_frames * 11 * max_div + 20000;

	// codes 56 and up go out as a space
	localparam int ascii_tab [56] = '{
		32, 65, 66, 67, 68, 69, 70, 71, 72, 73, 10, 74, 75, 76, 77, 78,
		79, 80, 81, 82, 13, 7, 83, 84, 85, 86, 87, 88, 89, 90, 48, 49,
		50, 51, 52, 53, 54, 55, 56, 57, 46, 44, 40, 41, 43, 45, 42, 47,
		61, 36, 60, 62, 64, 59, 58, 39
	};

	logic        clk;
	logic        rst;
	logic        char_valid;
	logic [5:0]  char_code;
	logic        reg_wr;
	logic [1:0]  reg_addr;
	logic [15:0] reg_wdata;
	logic [15:0] reg_rdata;
	logic        tx;
	logic        tx_idle;

	logic [31:0] lfsr;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          cycles;
	int          starts; // falling edges seen by the decoder

	// reference model
	logic [5:0]  mq [$];
	logic        m_two;
	logic        m_ovf;
	int          m_div;

	logic [7:0]  rx_q [$];
	logic        rx_stop_q [$];

	console_top DUT (
		.clk        (clk),
		.rst        (rst),
		.char_valid (char_valid),
		.char_code  (char_code),
		.reg_wr     (reg_wr),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.reg_rdata  (reg_rdata),
		.tx         (tx),
		.tx_idle    (tx_idle)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: run went past %0d cycles without finishing", cycle_limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [7:0] ascii_of(input logic [5:0] code);
		if (code > 6'd55)
			return 8'h20;
		return 8'(ascii_tab[code]);
	endfunction

	function automatic logic [15:0] expected_status();
		return {10'd0, 1'b0, m_ovf, 4'(mq.size())}; // busy low when quiet
	endfunction

	task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
		@(posedge clk);
		#1;
		reg_wr = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
		@(posedge clk);
		#1;
		reg_wr = 1'b0;
		case (addr)
			2'd0: m_two = data[1];
			2'd1: m_div = int'(data);
			2'd2: if (data[4]) m_ovf = 1'b0;
			default: ;
		endcase
	endtask

	task automatic push_code(input logic [5:0] code);
		@(posedge clk);
		#1;
		char_valid = 1'b1;
		char_code = code;
		@(posedge clk);
		#1;
		char_valid = 1'b0;
		if (mq.size() < 8)
			mq.push_back(code);
		else
			m_ovf = 1'b1; // dropped
	endtask

	task automatic read_expect(input logic [1:0] addr, input logic [15:0] exp, input string name);
		logic [15:0] got;
		@(posedge clk);
		#1;
		reg_addr = addr;
		@(negedge clk);
		got = reg_rdata;
		assert (got === exp)
		else begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic compare_frames(input int n);
		logic [7:0] got;
		logic [7:0] exp;
		logic       stop_ok;
		for (int i = 0; i < n; i++) begin
			while (rx_q.size() == 0)
				@(posedge clk);
			got = rx_q.pop_front();
			stop_ok = rx_stop_q.pop_front();
			assert (mq.size() > 0)
			else begin
				$display("A frame arrived with no code left in the model queue");
				test_errors++;
			end
			if (mq.size() > 0) begin
				exp = ascii_of(mq.pop_front());
				assert (got === exp)
				else begin
					$display("Fail tx byte: got %h, expected %h", got, exp);
					test_errors++;
				end
			end
			assert (stop_ok)
			else begin
				$display("Start bit was not low or the line dropped during the stop bits");
				test_errors++;
			end
		end
	endtask

	task automatic end_test(input string name);
		if (test_errors == 0)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, test_errors);
		errors += test_errors;
		test_errors = 0;
		tests_run++;
	endtask

	// samples mid-bit with the divisor the model holds at the start edge
	initial begin : line_decoder
		int         div;
		int         nbits;
		logic [7:0] data;
		logic       ok;
		@(negedge rst);
		forever begin
			@(negedge tx);
			starts++;
			div = (m_div < 2) ? 2 : m_div;
			nbits = m_two ? 11 : 10;
			data = '0;
			ok = 1'b1;
			for (int j = 0; j < nbits * div; j++) begin
				@(negedge clk);
				if (j == div / 2)
					ok = ok & ~tx;
				else if (j % div == div / 2 && j < 9 * div)
					data = {tx, data[7:1]}; // lsb first
				if (j >= 9 * div)
					ok = ok & tx; // whole stop length high
			end
			rx_q.push_back(data);
			rx_stop_q.push_back(ok);
		end
	end

	initial begin : main
		logic [15:0] val;
		int          k;
		int          pushed;
		int          start_cnt;
		lfsr = 32'h924b_4ff9;
		rst = 1'b1;
		char_valid = 1'b0;
		char_code = 6'd0;
		reg_wr = 1'b0;
		reg_addr = 2'd0;
		reg_wdata = 16'h0000;
		m_two = 1'b0;
		m_ovf = 1'b0;
		m_div = 16;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		cycles = 0;
		starts = 0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		// translation and order with at most 4 codes waiting
		write_reg(2'd0, 16'h0001);
		pushed = 0;
		start_cnt = starts;
		for (int i = 0; i < 40; i++) begin
			while (pushed - (starts - start_cnt) >= 4)
				@(posedge clk);
			compare_frames(rx_q.size());
			repeat (rand_bits(6)) @(posedge clk);
			push_code(6'(rand_bits(6)));
			pushed++;
		end
		compare_frames(mq.size());
		end_test("test 1 translation and order");

		// register readback
		write_reg(2'd0, 16'h0000);
		for (int i = 0; i < 4; i++) begin
			val = 16'(rand_bits(16)) & 16'hfffe;
			write_reg(2'd0, val);
			read_expect(2'd0, val & 16'h0003, "reg_rdata ctrl");
			val = 16'(rand_bits(16));
			write_reg(2'd1, val);
			read_expect(2'd1, val, "reg_rdata div");
		end
		write_reg(2'd1, 16'd16);
		write_reg(2'd0, 16'h0000);
		k = int'(rand_bits(3));
		for (int i = 0; i < k; i++) begin
			push_code(6'(rand_bits(6)));
			read_expect(2'd2, expected_status(), "reg_rdata status");
		end
		write_reg(2'd0, 16'h0001);
		compare_frames(k);
		write_reg(2'd0, 16'h0000);
		end_test("test 2 register readback");

		// overflow
		for (int i = 0; i < 11; i++)
			push_code(6'(rand_bits(6)));
		read_expect(2'd2, expected_status(), "reg_rdata status");
		write_reg(2'd2, 16'h0010);
		read_expect(2'd2, expected_status(), "reg_rdata status");
		write_reg(2'd0, 16'h0001);
		compare_frames(8);
		repeat (11 * 16) @(posedge clk);
		assert (rx_q.size() == 0)
		else begin
			$display("Frames came out beyond the queue depth");
			test_errors++;
		end
		write_reg(2'd0, 16'h0000);
		read_expect(2'd2, expected_status(), "reg_rdata status");
		end_test("test 3 overflow");

		// divisor and stop bits with two frames per setting
		for (int i = 0; i < 12; i++) begin
			val = 16'(2 + int'(rand_bits(5)) % 19);
			write_reg(2'd1, val);
			write_reg(2'd0, {14'd0, 1'(rand_bits(1)), 1'b1});
			push_code(6'(rand_bits(6)));
			push_code(6'(rand_bits(6)));
			compare_frames(2);
		end
		end_test("test 4 divisor and stop bits");

		// enable hold
		write_reg(2'd1, 16'd8);
		write_reg(2'd0, 16'h0000);
		for (int i = 0; i < 5; i++)
			push_code(6'(rand_bits(6)));
		start_cnt = starts;
		write_reg(2'd0, 16'h0001);
		while (starts == start_cnt)
			@(posedge clk);
		write_reg(2'd0, 16'h0000); // mid-frame
		// one code on the line, the rest still queued
		read_expect(2'd2, {10'd0, 1'b1, m_ovf, 4'(mq.size() - 1)}, "reg_rdata status");
		compare_frames(1);
		start_cnt = starts;
		for (int i = 0; i < 3 * 11 * 8; i++) begin
			@(negedge clk);
			assert (tx_idle == 1'b0)
			else begin
				$display("tx_idle rose while codes were still queued");
				test_errors++;
			end
		end
		assert (starts == start_cnt)
		else begin
			$display("A new frame started while enable was low");
			test_errors++;
		end
		write_reg(2'd0, 16'h0001);
		compare_frames(4);
		@(posedge clk);
		@(negedge clk);
		assert (tx_idle === 1'b1)
		else begin
			$display("tx_idle did not rise after the queue drained");
			test_errors++;
		end
		end_test("test 5 enable hold");

		$display("tests run %0d, errors %0d", tests_run, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- sources.f
+incdir+design
design/charset_pkg.sv
design/link_pkg.sv
design/link_ctrl_if.sv
design/char_fifo.sv
design/console_regs.sv
design/uart_tx.sv
design/console_top.sv
test/console_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the console testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
build=obj_dir

verilator --binary --timing --assert -f sources.f --top-module console_tb \
	-Mdir "$build" -o console_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

"./$build/console_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '^>>> PASS$' "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
